// ==== all.f ====
+incdir+.
bpu_pkg.sv
btb_way_ram.sv
btb_write_ctrl.sv
btb_lookup.sv
bpu_ghist.sv
bpu_top.sv
tb_bpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the output for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_bpu -o tb_bpu

out=$(./obj_dir/tb_bpu)
echo "$out"
echo "$out" | grep -q '^>>> PASS$'

// ==== tb_bpu.sv ====
// Testbench for the BPU front end, checked against a reference model of BTB, LFSR and BHR
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tb_bpu
    import bpu_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int N_RAND          = 300;
    localparam int TOTAL_OPS       = 8 + 16 + 11 + 5 + 54 + N_RAND;
    localparam int WATCHDOG_CYCLES = 200 + 20 * TOTAL_OPS;
    // Set hash rows over PC[14:1], row 6 first
    localparam logic [6:0][13:0] HASH_MASK = {14'h3E40, 14'h3F20, 14'h3F90, 14'h2188,
                                              14'h0E84, 14'h3902, 14'h3C81};

    logic                      core_clk;
    logic                      core_reset_n;
    logic                      rd_valid;
    logic [`BPU_VALEN-1:0]     rd_pc;
    logic                      rd_ready;
    logic                      rd_ack;
    bpu_pred_t                 pred;
    logic                      upd_valid;
    btb_update_t               upd;
    logic [`BPU_HIST_BITS-1:0] bht_rd_addr;
    logic [1:0]                bht_rdata;
    logic                      init_done;

    btb_entry_t                model_ways [2][`BPU_SETS];
    logic [`BPU_LFSR_BITS-1:0] model_lfsr;
    logic [`BPU_HIST_BITS-1:0] model_bhr  = '0;
    logic [`BPU_HIST_BITS-1:0] bht_addr_q = '0;
    logic                      ack_exp    = 1'b0;
    logic [31:0]               pend_q [$];           // Accepted PCs awaiting rd_ack
    logic [31:0]               burst_q [$];
    logic [31:0]               pool [16];
    int                        seed;
    int                        err_count   = 0;
    int                        err_mark    = 0;
    int                        check_count = 0;
    int                        tests_run   = 0;
    int                        tests_failed = 0;

    bpu_top DUT (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .rd_valid     (rd_valid),
        .rd_pc        (rd_pc),
        .rd_ready     (rd_ready),
        .rd_ack       (rd_ack),
        .pred         (pred),
        .upd_valid    (upd_valid),
        .upd          (upd),
        .bht_rd_addr  (bht_rd_addr),
        .bht_rdata    (bht_rdata),
        .init_done    (init_done)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    // ****************************************
    // Reference model
    // ****************************************
    function automatic logic [6:0] set_index(input logic [31:0] pc);
        logic [6:0] idx;
        int         b;
        for (b = 0; b < 7; b++) begin
            idx[b] = ^(pc[14:1] & HASH_MASK[b]);
        end
        return idx;
    endfunction

    function automatic logic [1:0] bht_rule(input logic [7:0] addr);
        return addr[1:0] ^ addr[3:2];                 // Fixed counter table
    endfunction

    function automatic bpu_pred_t predict(input logic [31:0] pc);
        bpu_pred_t  p;
        btb_entry_t e0;
        btb_entry_t e1;
        btb_entry_t sel;
        logic       m0;
        logic       m1;
        logic [1:0] cnt;
        e0  = model_ways[0][set_index(pc)];
        e1  = model_ways[1][set_index(pc)];
        m0  = e0.valid && (e0.tag == pc[31:8]);
        m1  = e1.valid && (e1.tag == pc[31:8]);
        cnt = bht_rule(pc[8:1] ^ model_bhr);
        p   = '0;
        p.start_pc     = pc;
        p.target       = pc;
        p.fall_thru_pc = pc;
        if (m0 || m1) begin
            sel            = m0 ? e0 : e1;
            p.hit          = 1'b1;
            p.way          = !m0;
            p.ucond        = sel.ucond;
            p.pred_cnt     = cnt;
            p.taken        = sel.ucond || cnt[1];
            p.offset       = sel.blk_offset;
            p.target       = {pc[31:17], sel.target_lo, 1'b0};
            p.fall_thru_pc = pc + {21'd0, sel.blk_offset, 1'b0};
        end
        return p;
    endfunction

    function automatic btb_update_t make_upd(input logic [31:0] pc, input logic ucond,
                                             input logic alloc, input logic way,
                                             input logic far);
        btb_update_t u;
        logic [31:0] r;
        r               = $random(seed);
        u.start_pc      = pc;
        u.target_pc     = {pc[31:17], r[15:0], 1'b0};
        u.target_pc[24] = far ? ~pc[24] : pc[24];      // Upper bits differ when far
        u.blk_offset    = r[25:16];
        u.ucond         = ucond;
        u.alloc         = alloc;
        u.way           = way;
        return u;
    endfunction

    // ****************************************
    // Checks and stimulus tasks
    // ****************************************
    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_pred(input bpu_pred_t got, input bpu_pred_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: pred expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_addr(input logic [`BPU_HIST_BITS-1:0] got,
                              input logic [`BPU_HIST_BITS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: bht_rd_addr expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic send_update(input btb_update_t u);
        logic       far;
        logic       w;
        btb_entry_t e;
        far       = u.target_pc[31:17] != u.start_pc[31:17];
        upd       = u;
        upd_valid = 1'b1;
        @(posedge core_clk);
        if (!far) begin
            w = u.alloc ? model_lfsr[4] : u.way;
            if (u.alloc) begin
                model_lfsr = {model_lfsr[3:0], 1'b0} ^ (model_lfsr[4] ? 5'b00101 : 5'b00000);
            end
            e.valid      = 1'b1;
            e.tag        = u.start_pc[31:8];
            e.target_lo  = u.target_pc[16:1];
            e.blk_offset = u.blk_offset;
            e.ucond      = u.ucond;
            model_ways[w][set_index(u.start_pc)] = e;
        end
        @(negedge core_clk);
        upd_valid = 1'b0;
        check_bit("rd_ready", rd_ready, far);         // Low only in a real write cycle
    endtask

    task automatic run_lookups;
        int i;
        for (i = 0; i < burst_q.size(); i++) begin
            while (!rd_ready) begin
                rd_valid = 1'b0;
                @(negedge core_clk);
            end
            rd_valid = 1'b1;
            rd_pc    = burst_q[i];
            @(negedge core_clk);
        end
        rd_valid = 1'b0;
        while (pend_q.size() != 0) begin
            @(negedge core_clk);
        end
        burst_q.delete();
    endtask

    task automatic lookup_one(input logic [31:0] pc);
        burst_q.push_back(pc);
        run_lookups();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != err_mark) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err_mark);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = err_count;
    endtask

    // ****************************************
    // Monitor and BHT model
    // ****************************************
    always @(posedge core_clk) begin : monitor
        logic [31:0] pc;
        bpu_pred_t   exp;
        if (core_reset_n) begin
            check_bit("rd_ack", rd_ack, ack_exp);
            if (rd_ack && pend_q.size() == 0) begin
                err_count++;
                $display("rd_ack rose with no lookup in flight at %0t ns", $time);
            end else if (rd_ack) begin
                pc  = pend_q.pop_front();
                exp = predict(pc);
                check_pred(pred, exp);
                if (exp.hit && !exp.ucond) begin
                    model_bhr = {exp.pred_cnt[1], model_bhr[7:1]};
                end
            end
            ack_exp = rd_valid && rd_ready;
            check_addr(bht_rd_addr, ack_exp ? (rd_pc[8:1] ^ model_bhr) : 8'h00);
            if (ack_exp) begin
                pend_q.push_back(rd_pc);
            end
        end
        bht_addr_q = bht_rd_addr;
    end

    always @(negedge core_clk) begin
        bht_rdata = bht_rule(bht_addr_q);             // Held through the result cycle
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        int          n;
        logic [31:0] r;
        logic [31:0] pc;
        seed         = 14;
        core_clk     = 1'b0;
        core_reset_n = 1'b0;
        rd_valid     = 1'b0;
        rd_pc        = '0;
        upd_valid    = 1'b0;
        upd          = '0;
        bht_rdata    = 2'b00;
        model_lfsr   = `BPU_LFSR_SEED;
        for (n = 0; n < `BPU_SETS; n++) begin
            model_ways[0][n] = '0;
            model_ways[1][n] = '0;
        end

        @(negedge core_clk);
        check_bit("init_done", init_done, 1'b0);
        check_bit("rd_ack", rd_ack, 1'b0);
        check_pred(pred, '0);
        repeat (4) @(negedge core_clk);
        core_reset_n = 1'b1;
        for (n = 1; n <= 130; n++) begin
            @(negedge core_clk);
            check_bit("init_done", init_done, n >= 128);   // One set per cycle
            check_bit("rd_ready", rd_ready, n >= 128);
        end
        for (n = 0; n < 8; n++) begin
            r = $random(seed);
            burst_q.push_back(r & 32'hFFFF_FFFE);
        end
        run_lookups();
        end_test("1 reset sweep and misses");

        for (n = 0; n < 8; n++) begin
            r       = $random(seed);
            pool[n] = r & 32'hFFFF_FFFE;
            send_update(make_upd(pool[n], r[0], 1'b1, 1'b0, 1'b0));
        end
        for (n = 0; n < 8; n++) begin
            burst_q.push_back(pool[n]);
        end
        run_lookups();
        end_test("2 allocating updates");

        pc = 32'h4C31_2A5C;
        send_update(make_upd(pc, 1'b0, 1'b0, 1'b0, 1'b0));
        lookup_one(pc);
        send_update(make_upd(pc ^ 32'h0010_0000, 1'b0, 1'b0, 1'b1, 1'b0));
        burst_q = '{pc, pc ^ 32'h0010_0000};
        run_lookups();
        send_update(make_upd(pc, 1'b1, 1'b0, 1'b1, 1'b0));   // Both ways now match
        burst_q = '{pc, pc ^ 32'h0010_0000};
        run_lookups();
        send_update(make_upd(pc ^ 32'h0200_0000, 1'b0, 1'b0, 1'b0, 1'b0));
        burst_q = '{pc, pc ^ 32'h0200_0000};
        run_lookups();
        end_test("3 directed updates");

        pc = 32'h7E05_13A0;
        send_update(make_upd(pc, 1'b0, 1'b1, 1'b0, 1'b1));
        send_update(make_upd(pc, 1'b0, 1'b0, 1'b1, 1'b1));
        lookup_one(pc);
        send_update(make_upd(pc, 1'b0, 1'b1, 1'b0, 1'b0));   // LFSR must not have moved
        lookup_one(pc);
        end_test("4 far updates");

        for (n = 0; n < 6; n++) begin
            r       = $random(seed);
            pool[n] = r & 32'hFFFF_FFFE;
            send_update(make_upd(pool[n], n >= 4, 1'b1, 1'b0, 1'b0));
        end
        for (n = 0; n < 48; n++) begin
            r = $random(seed);
            burst_q.push_back((r[2:0] < 3'd6) ? pool[r[2:0]] : (r & 32'hFFFF_FFFE));
            if (n % 12 == 11) begin
                run_lookups();
            end
        end
        end_test("5 direction and history");

        for (n = 0; n < 16; n++) begin
            r       = $random(seed);
            pool[n] = (n < 4) ? (r & 32'hFFFF_FFFE) : {r[31:15], pool[n % 4][14:0]};
        end
        for (n = 0; n < N_RAND; n++) begin
            r  = $random(seed);
            pc = pool[r[7:4]];
            if (r[2:0] < 3'd3) begin
                send_update(make_upd(pc, r[13], r[11], r[12], r[10:8] == 3'd0));
            end else begin
                lookup_one((r[15:14] != 2'b00) ? pc : (r & 32'hFFFF_FFFE));
            end
        end
        end_test("6 random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bpu_top.sv ====
// Branch prediction front end with two BTB ways, write control, lookup and gshare
`timescale 1ns/1ps
`include "bpu_defs.svh"

module bpu_top
    import bpu_pkg::*;
(
    input  logic                      core_clk,
    input  logic                      core_reset_n,
    input  logic                      rd_valid,
    input  logic [`BPU_VALEN-1:0]     rd_pc,
    output logic                      rd_ready,
    output logic                      rd_ack,
    output bpu_pred_t                 pred,
    input  logic                      upd_valid,
    input  btb_update_t               upd,
    output logic [`BPU_HIST_BITS-1:0] bht_rd_addr,
    input  logic [1:0]                bht_rdata,
    output logic                      init_done
);

    logic                     wr_en0;
    logic                     wr_en1;
    logic [`BPU_SET_BITS-1:0] wr_idx;
    btb_entry_t               wr_entry;
    logic                     wr_busy;
    logic                     rd_en;
    logic [`BPU_SET_BITS-1:0] rd_idx;
    btb_entry_t               rd_entry0;
    btb_entry_t               rd_entry1;
    logic                     cond_hit;
    logic                     cond_taken;

    btb_write_ctrl u_write_ctrl (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .upd_valid    (upd_valid),
        .upd          (upd),
        .wr_en0       (wr_en0),
        .wr_en1       (wr_en1),
        .wr_idx       (wr_idx),
        .wr_entry     (wr_entry),
        .wr_busy      (wr_busy),
        .init_done    (init_done)
    );

    // ****************************************
    // BTB ways
    // ****************************************
    btb_way_ram u_way0 (
        .core_clk (core_clk),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry0),
        .wr_en    (wr_en0),
        .wr_idx   (wr_idx),
        .wr_entry (wr_entry)
    );

    btb_way_ram u_way1 (
        .core_clk (core_clk),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry1),
        .wr_en    (wr_en1),
        .wr_idx   (wr_idx),
        .wr_entry (wr_entry)
    );

    btb_lookup u_lookup (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .rd_valid     (rd_valid),
        .rd_pc        (rd_pc),
        .rd_ready     (rd_ready),
        .wr_busy      (wr_busy),
        .init_done    (init_done),
        .rd_en        (rd_en),
        .rd_idx       (rd_idx),
        .rd_entry0    (rd_entry0),
        .rd_entry1    (rd_entry1),
        .bht_rdata    (bht_rdata),
        .rd_ack       (rd_ack),
        .pred         (pred),
        .cond_hit     (cond_hit),
        .cond_taken   (cond_taken)
    );

    bpu_ghist u_ghist (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_pc        (rd_pc),
        .cond_hit     (cond_hit),
        .cond_taken   (cond_taken),
        .bht_rd_addr  (bht_rd_addr)
    );

endmodule

// ==== bpu_ghist.sv ====
// Gshare history with the branch history register and BHT read address
`timescale 1ns/1ps
`include "bpu_defs.svh"

module bpu_ghist
    import bpu_pkg::*;
(
    input  logic                      core_clk,
    input  logic                      core_reset_n,
    input  logic                      rd_valid,
    input  logic                      rd_ready,
    input  logic [`BPU_VALEN-1:0]     rd_pc,
    input  logic                      cond_hit,
    input  logic                      cond_taken,
    output logic [`BPU_HIST_BITS-1:0] bht_rd_addr
);

    logic [`BPU_HIST_BITS-1:0] bhr;
    logic [`BPU_HIST_BITS-1:0] bhr_next;

    // ****************************************
    // Branch history register
    // ****************************************
    assign bhr_next = cond_hit ? {cond_taken, bhr[`BPU_HIST_BITS-1:1]} : bhr;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            bhr <= '0;
        end else begin
            bhr <= bhr_next;                 // Shifts on an acked cond hit
        end
    end

    // ****************************************
    // BHT index
    // ****************************************
    // A lookup right behind a conditional hit already sees that outcome
    assign bht_rd_addr = (rd_valid & rd_ready) ? (rd_pc[`BPU_HIST_BITS:1] ^ bhr_next)
                                               : '0;

endmodule

// ==== btb_lookup.sv ====
// BTB lookup with tag compare, way select and prediction formation
`timescale 1ns/1ps
`include "bpu_defs.svh"

module btb_lookup
    import bpu_pkg::*;
(
    input  logic                     core_clk,
    input  logic                     core_reset_n,
    input  logic                     rd_valid,
    input  logic [`BPU_VALEN-1:0]    rd_pc,
    output logic                     rd_ready,
    input  logic                     wr_busy,
    input  logic                     init_done,
    output logic                     rd_en,
    output logic [`BPU_SET_BITS-1:0] rd_idx,
    input  btb_entry_t               rd_entry0,
    input  btb_entry_t               rd_entry1,
    input  logic [1:0]               bht_rdata,
    output logic                     rd_ack,
    output bpu_pred_t                pred,
    output logic                     cond_hit,
    output logic                     cond_taken
);

    logic                     accept;
    logic                     ack_q;
    logic [`BPU_VALEN-1:0]    pc_q;
    logic [`BPU_TAG_BITS-1:0] pc_tag;
    logic                     match0;
    logic                     match1;
    logic                     hit;
    btb_entry_t               sel;
    logic [`BPU_OFS_BITS-1:0] offset;

    // ****************************************
    // Accept and array read
    // ****************************************
    assign rd_ready = init_done & ~wr_busy;   // Blocked in the write cycle
    assign accept   = rd_valid & rd_ready;
    assign rd_en    = accept;
    assign rd_idx   = btb_set_hash(rd_pc[14:1]);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            ack_q <= 1'b0;
            pc_q  <= '0;
        end else begin
            ack_q <= accept;
            if (accept) begin
                pc_q <= rd_pc;
            end
        end
    end

    // ****************************************
    // Compare stage
    // ****************************************
    assign pc_tag = pc_q[`BPU_VALEN-1:`BPU_VALEN-`BPU_TAG_BITS];
    assign match0 = ack_q & rd_entry0.valid & (rd_entry0.tag == pc_tag);
    assign match1 = ack_q & rd_entry1.valid & (rd_entry1.tag == pc_tag);
    assign hit    = match0 | match1;
    assign sel    = match0 ? rd_entry0 : rd_entry1;   // Way 0 wins a double match
    assign offset = hit ? sel.blk_offset : '0;

    assign rd_ack            = ack_q;
    assign pred.hit          = hit;
    assign pred.way          = match1 & ~match0;
    assign pred.ucond        = hit & sel.ucond;
    assign pred.taken        = hit & (sel.ucond | bht_rdata[1]);
    assign pred.start_pc     = pc_q;
    assign pred.offset       = offset;
    assign pred.pred_cnt     = hit ? bht_rdata : 2'b00;

    // Upper target bits come from the fetch PC
    assign pred.target       = hit ? {pc_q[`BPU_VALEN-1:`BPU_TGT_BITS+1], sel.target_lo, 1'b0}
                                   : pc_q;
    assign pred.fall_thru_pc = pc_q + {{(`BPU_VALEN-`BPU_OFS_BITS-1){1'b0}}, offset, 1'b0};

    // History update for conditional branches only
    assign cond_hit   = hit & ~sel.ucond;
    assign cond_taken = bht_rdata[1];

    // Swept ways never return unknown entries
    a_known_match: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        rd_ack |-> !$isunknown({match0, match1}));

endmodule

// ==== btb_write_ctrl.sv ====
// BTB write controller for the reset sweep, update stage and LFSR way choice
`timescale 1ns/1ps
`include "bpu_defs.svh"

module btb_write_ctrl
    import bpu_pkg::*;
(
    input  logic                     core_clk,
    input  logic                     core_reset_n,
    input  logic                     upd_valid,
    input  btb_update_t              upd,
    output logic                     wr_en0,
    output logic                     wr_en1,
    output logic [`BPU_SET_BITS-1:0] wr_idx,
    output btb_entry_t               wr_entry,
    output logic                     wr_busy,
    output logic                     init_done
);

    logic                      sweep_on;
    logic [`BPU_SET_BITS-1:0]  sweep_idx;
    logic [`BPU_LFSR_BITS-1:0] lfsr;
    logic [`BPU_LFSR_BITS-1:0] lfsr_next;
    logic                      upd_far;
    logic                      upd_take;
    logic                      stg_valid;
    logic                      stg_way;
    logic [`BPU_SET_BITS-1:0]  stg_idx;
    btb_entry_t                stg_entry;

    // ****************************************
    // Clear sweep after reset
    // ****************************************
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            sweep_on  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweep_on) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweep_on <= 1'b0;              // Last set cleared
            end
        end
    end

    assign init_done = ~sweep_on;

    // ****************************************
    // Way choice LFSR
    // ****************************************
    // Galois form, feedback into bit 3 counting from 1
    assign lfsr_next = {lfsr[3], lfsr[2], lfsr[1] ^ lfsr[4], lfsr[0], lfsr[4]};

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            lfsr <= `BPU_LFSR_SEED;
        end else if (upd_take && upd.alloc) begin
            lfsr <= lfsr_next;                 // Once per written alloc
        end
    end

    // ****************************************
    // Update capture stage
    // ****************************************
    assign upd_far  = upd.target_pc[`BPU_VALEN-1:`BPU_TGT_BITS+1]
                      != upd.start_pc[`BPU_VALEN-1:`BPU_TGT_BITS+1];
    assign upd_take = upd_valid & ~upd_far;   // Far targets never stored

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            stg_valid <= 1'b0;
        end else begin
            stg_valid <= upd_take;
        end
    end

    always_ff @(posedge core_clk) begin
        if (upd_take) begin
            stg_way              <= upd.alloc ? lfsr[`BPU_LFSR_BITS-1] : upd.way;
            stg_idx              <= btb_set_hash(upd.start_pc[14:1]);
            stg_entry.valid      <= 1'b1;
            stg_entry.tag        <= upd.start_pc[`BPU_VALEN-1:`BPU_VALEN-`BPU_TAG_BITS];
            stg_entry.target_lo  <= upd.target_pc[`BPU_TGT_BITS:1];
            stg_entry.blk_offset <= upd.blk_offset;
            stg_entry.ucond      <= upd.ucond;
        end
    end

    // ****************************************
    // Shared write bus
    // ****************************************
    assign wr_busy  = stg_valid;
    assign wr_en0   = sweep_on | (stg_valid & ~stg_way);
    assign wr_en1   = sweep_on | (stg_valid & stg_way);
    assign wr_idx   = sweep_on ? sweep_idx : stg_idx;
    assign wr_entry = sweep_on ? btb_entry_t'('0) : stg_entry;

    a_no_upd_before_init: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        upd_valid |-> init_done);

    a_known_write: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        wr_busy |-> !$isunknown({stg_way, stg_idx, stg_entry}));

endmodule

// ==== btb_way_ram.sv ====
// BTB way array with a registered read port and a synchronous write port
`timescale 1ns/1ps
`include "bpu_defs.svh"

module btb_way_ram
    import bpu_pkg::*;
(
    input  logic                     core_clk,
    input  logic                     rd_en,
    input  logic [`BPU_SET_BITS-1:0] rd_idx,
    output btb_entry_t               rd_entry,
    input  logic                     wr_en,
    input  logic [`BPU_SET_BITS-1:0] wr_idx,
    input  btb_entry_t               wr_entry
);

    btb_entry_t mem [`BPU_SETS];

    // ****************************************
    // Write port
    // ****************************************
    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    // ****************************************
    // Read port
    // ****************************************
    always_ff @(posedge core_clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_idx];   // Data one cycle after rd_en
        end
    end

endmodule

// ==== bpu_pkg.sv ====
// BPU shared types for the BTB entry, update request, lookup result and set hash
`include "bpu_defs.svh"

package bpu_pkg;

    typedef struct packed {
        logic                     valid;
        logic [`BPU_TAG_BITS-1:0] tag;         // PC[31:8]
        logic [`BPU_TGT_BITS-1:0] target_lo;   // Target PC[16:1]
        logic [`BPU_OFS_BITS-1:0] blk_offset;
        logic                     ucond;
    } btb_entry_t;

    typedef struct packed {
        logic [`BPU_VALEN-1:0]    start_pc;
        logic [`BPU_VALEN-1:0]    target_pc;
        logic [`BPU_OFS_BITS-1:0] blk_offset;
        logic                     ucond;
        logic                     alloc;       // Way from LFSR
        logic                     way;         // Way when not alloc
    } btb_update_t;

    typedef struct packed {
        logic                     hit;
        logic                     way;
        logic                     taken;
        logic                     ucond;
        logic [`BPU_VALEN-1:0]    start_pc;
        logic [`BPU_VALEN-1:0]    target;
        logic [`BPU_VALEN-1:0]    fall_thru_pc;
        logic [`BPU_OFS_BITS-1:0] offset;
        logic [1:0]               pred_cnt;
    } bpu_pred_t;

    // GF(2) fold of PC[14:1] down to a set index
    function automatic logic [`BPU_SET_BITS-1:0] btb_set_hash(input logic [13:0] pc);
        logic [`BPU_SET_BITS-1:0] idx;
        idx[6] = pc[6] ^ pc[9] ^ pc[10] ^ pc[11] ^ pc[12] ^ pc[13];
        idx[5] = pc[5] ^ pc[8] ^ pc[9] ^ pc[10] ^ pc[11] ^ pc[12] ^ pc[13];
        idx[4] = pc[4] ^ pc[7] ^ pc[8] ^ pc[9] ^ pc[10] ^ pc[11] ^ pc[12] ^ pc[13];
        idx[3] = pc[3] ^ pc[7] ^ pc[8] ^ pc[13];
        idx[2] = pc[2] ^ pc[7] ^ pc[9] ^ pc[10] ^ pc[11];
        idx[1] = pc[1] ^ pc[8] ^ pc[11] ^ pc[12] ^ pc[13];
        idx[0] = pc[0] ^ pc[7] ^ pc[10] ^ pc[11] ^ pc[12] ^ pc[13];
        return idx;
    endfunction

endpackage

// ==== bpu_defs.svh ====
// BPU configuration macros for address, BTB entry and branch history widths
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// ****************************************
// Address and BTB geometry
// ****************************************
`define BPU_VALEN      32                    // Virtual address width
`define BPU_SET_BITS   7                     // Set index width
`define BPU_SETS       (1 << `BPU_SET_BITS)  // 128 sets per way
`define BPU_TAG_BITS   24                    // PC[31:8]
`define BPU_TGT_BITS   16                    // PC[16:1] kept per entry
`define BPU_OFS_BITS   10                    // Halfwords from block start

// ****************************************
// Way choice and direction history
// ****************************************
`define BPU_LFSR_BITS  5
`define BPU_LFSR_SEED  5'd1
`define BPU_HIST_BITS  8                     // BHR and BHT index width

`endif
